// File: hw/cnn_pkg.sv
package cnn_pkg;

    //////////////////////////////////////////////////////////////////////
    // Sizes
    //////////////////////////////////////////////////////////////////////

    localparam int LANES      = 4;
    localparam int DATA_W     = 8;
    localparam int ACC_W      = 20;
    localparam int QSHIFT     = 4;
    localparam int CONV_AW    = 9;
    localparam int POOL_AW    = 6;
    localparam int FC_IN_MAX  = 16;
    localparam int FC_OUT_MAX = 8;

    localparam int DATA_MAX = 2 ** (DATA_W - 1) - 1;
    localparam int DATA_MIN = -(2 ** (DATA_W - 1));

    //////////////////////////////////////////////////////////////////////
    // Types
    //////////////////////////////////////////////////////////////////////

    typedef logic signed [DATA_W-1:0] data_t;
    typedef logic [POOL_AW-1:0] pool_addr_t;

    // Encoded on the 2-bit request port of the top level
    typedef enum logic [1:0] {
        OP_IDLE = 2'd0,
        OP_CONV = 2'd1,
        OP_FC   = 2'd2
    } op_e;

    typedef enum logic [1:0] {
        CS_IDLE,
        CS_MAC,
        CS_EMIT
    } conv_state_e;

    typedef enum logic [1:0] {
        FS_IDLE,
        FS_MAC,
        FS_EMIT
    } fc_state_e;

    // Arithmetic shift by QSHIFT, then clamp into a signed byte
    function automatic data_t requant(input logic signed [ACC_W-1:0] acc);
        logic signed [ACC_W-1:0] shifted;
        shifted = acc >>> QSHIFT;
        if (shifted > DATA_MAX) begin
            return data_t'(DATA_MAX);
        end
        if (shifted < DATA_MIN) begin
            return data_t'(DATA_MIN);
        end
        return data_t'(shifted);
    endfunction

endpackage

// File: hw/conv_array.sv
module conv_array (
    input  logic                         clk,
    input  logic                         rst_n_i,
    input  logic                         start_i,
    input  logic [1:0]                   nth_conv_i,
    input  logic [3:0]                   ofmap_size_i,
    input  logic                         wea_i,
    input  logic [cnn_pkg::CONV_AW-1:0]  addra_i,
    input  cnn_pkg::data_t               dia_i,
    output logic                         conv_valid_o,
    output cnn_pkg::data_t               conv_data_o [cnn_pkg::LANES],
    output logic [3:0]                   conv_row_o,
    output logic [3:0]                   conv_col_o
);

    cnn_pkg::data_t weight_mem [64];
    cnn_pkg::data_t ifmap_mem [256];

    cnn_pkg::conv_state_e state_q;
    logic [1:0] tap_q;
    logic [3:0] row_q;
    logic [3:0] col_q;
    logic [3:0] size_q;
    logic [1:0] nth_q;

    logic signed [cnn_pkg::ACC_W-1:0] acc_q [cnn_pkg::LANES];

    logic [7:0] side;
    logic [7:0] pix_row;
    logic [7:0] pix_col;
    logic [7:0] pix_addr;
    cnn_pkg::data_t pixel;
    cnn_pkg::data_t lane_w [cnn_pkg::LANES];
    logic last_col;
    logic last_px;

    //////////////////////////////////////////////////////////////////////
    // Load port
    //////////////////////////////////////////////////////////////////////

    // Bit 8 picks the ifmap region, otherwise the 64-byte weight region
    always_ff @(posedge clk) begin
        if (wea_i) begin
            if (addra_i[8]) begin
                ifmap_mem[addra_i[7:0]] <= dia_i;
            end else begin
                weight_mem[addra_i[5:0]] <= dia_i;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Tap addressing
    //////////////////////////////////////////////////////////////////////

    // Taps are row-major, so bit 1 is the row offset and bit 0 the column
    always_comb begin
        side     = {4'd0, size_q} + 8'd1;
        pix_row  = {4'd0, row_q} + {7'd0, tap_q[1]};
        pix_col  = {4'd0, col_q} + {7'd0, tap_q[0]};
        pix_addr = pix_row * side + pix_col;
        pixel    = ifmap_mem[pix_addr];
        for (int l = 0; l < cnn_pkg::LANES; l++) begin
            lane_w[l] = weight_mem[{nth_q, l[1:0], tap_q}];
        end
        last_col = col_q == size_q - 4'd1;
        last_px  = last_col && (row_q == size_q - 4'd1);
    end

    //////////////////////////////////////////////////////////////////////
    // Sequencer
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q      <= cnn_pkg::CS_IDLE;
            tap_q        <= 2'd0;
            row_q        <= 4'd0;
            col_q        <= 4'd0;
            conv_valid_o <= 1'b0;
        end else begin
            conv_valid_o <= 1'b0;
            case (state_q)
                cnn_pkg::CS_IDLE: begin
                    if (start_i) begin
                        state_q <= cnn_pkg::CS_MAC;
                        tap_q   <= 2'd0;
                        row_q   <= 4'd0;
                        col_q   <= 4'd0;
                    end
                end
                cnn_pkg::CS_MAC: begin
                    tap_q <= tap_q + 2'd1;
                    if (tap_q == 2'd3) begin
                        state_q <= cnn_pkg::CS_EMIT;
                    end
                end
                cnn_pkg::CS_EMIT: begin
                    conv_valid_o <= 1'b1;
                    if (last_px) begin
                        state_q <= cnn_pkg::CS_IDLE;
                    end else begin
                        state_q <= cnn_pkg::CS_MAC;
                        if (last_col) begin
                            col_q <= 4'd0;
                            row_q <= row_q + 4'd1;
                        end else begin
                            col_q <= col_q + 4'd1;
                        end
                    end
                end
                default: state_q <= cnn_pkg::CS_IDLE;
            endcase
        end
    end

    // All lanes share one pixel per MAC cycle
    always_ff @(posedge clk) begin
        if (state_q == cnn_pkg::CS_IDLE && start_i) begin
            size_q <= ofmap_size_i;
            nth_q  <= nth_conv_i;
        end
        if (state_q == cnn_pkg::CS_MAC) begin
            for (int l = 0; l < cnn_pkg::LANES; l++) begin
                acc_q[l] <= (tap_q == 2'd0) ? pixel * lane_w[l]
                                            : acc_q[l] + pixel * lane_w[l];
            end
        end
        if (state_q == cnn_pkg::CS_EMIT) begin
            for (int l = 0; l < cnn_pkg::LANES; l++) begin
                conv_data_o[l] <= cnn_pkg::requant(acc_q[l]);
            end
            conv_row_o <= row_q;
            conv_col_o <= col_q;
        end
    end

endmodule

// File: hw/pool_lane.sv
module pool_lane (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic                 start_i,
    input  logic [3:0]           ofmap_size_i,
    input  logic                 conv_valid_i,
    input  cnn_pkg::data_t       conv_data_i,
    input  logic [3:0]           conv_row_i,
    input  logic [3:0]           conv_col_i,
    output logic                 pool_valid_o,
    output logic                 pool_last_o,
    output cnn_pkg::data_t       pool_result_o,
    output cnn_pkg::pool_addr_t  pool_result_address_o
);

    logic active_q;
    logic [3:0] size_q;
    cnn_pkg::data_t pair_q;
    cnn_pkg::data_t row_buf [7];

    logic take;
    logic final_px;
    logic start_ok;
    logic [2:0] buf_idx;
    cnn_pkg::data_t relu;
    cnn_pkg::data_t pair_max;
    cnn_pkg::data_t pool_max;
    cnn_pkg::pool_addr_t addr_next;

    always_comb begin
        take     = conv_valid_i && active_q;
        final_px = take && (conv_row_i == size_q - 4'd1) && (conv_col_i == size_q - 4'd1);
        // A new run may start in the same cycle the final pixel arrives
        start_ok = start_i && (!active_q || final_px);
        buf_idx  = conv_col_i[3:1];
        relu     = conv_data_i[cnn_pkg::DATA_W-1] ? '0 : conv_data_i;
        pair_max = (relu > pair_q) ? relu : pair_q;
        pool_max = (row_buf[buf_idx] > pair_max) ? row_buf[buf_idx] : pair_max;
        addr_next = cnn_pkg::pool_addr_t'(conv_row_i[3:1]) * cnn_pkg::pool_addr_t'(size_q[3:1])
                  + cnn_pkg::pool_addr_t'(conv_col_i[3:1]);
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            active_q     <= 1'b0;
            pool_valid_o <= 1'b0;
            pool_last_o  <= 1'b0;
        end else begin
            if (start_ok) begin
                active_q <= 1'b1;
            end else if (final_px) begin
                active_q <= 1'b0;
            end
            pool_valid_o <= take && conv_row_i[0] && conv_col_i[0];
            pool_last_o  <= final_px;
        end
    end

    // Even rows fill the buffer, odd rows close each 2x2 window
    always_ff @(posedge clk) begin
        if (start_ok) begin
            size_q <= ofmap_size_i;
        end
        if (take && !conv_col_i[0]) begin
            pair_q <= relu;
        end
        if (take && conv_col_i[0] && !conv_row_i[0]) begin
            row_buf[buf_idx] <= pair_max;
        end
        if (take && conv_col_i[0] && conv_row_i[0]) begin
            pool_result_o         <= pool_max;
            pool_result_address_o <= addr_next;
        end
    end

endmodule

// File: hw/fc_engine.sv
module fc_engine (
    input  logic            clk,
    input  logic            rst_n_i,
    input  logic            start_i,
    input  logic [4:0]      in_node_num_i,
    input  logic [3:0]      out_node_num_i,
    input  logic            wbuf_wren_i,
    input  logic [6:0]      wbuf_addr_i,
    input  cnn_pkg::data_t  wbuf_wdata_i,
    input  logic            ifmap_wren_i,
    input  logic [3:0]      ifmap_wrptr_i,
    input  cnn_pkg::data_t  ifmap_wdata_i,
    output logic            fc_valid_o,
    output logic            fc_last_o,
    output cnn_pkg::data_t  fc_result_o
);

    cnn_pkg::data_t wbuf [cnn_pkg::FC_IN_MAX * cnn_pkg::FC_OUT_MAX];
    cnn_pkg::data_t ibuf [cnn_pkg::FC_IN_MAX];

    cnn_pkg::fc_state_e state_q;
    logic [3:0] idx_q;
    logic [2:0] node_q;
    logic [4:0] in_num_q;
    logic [3:0] out_num_q;
    logic signed [cnn_pkg::ACC_W-1:0] acc_q;

    logic last_in;
    logic last_node;

    //////////////////////////////////////////////////////////////////////
    // Buffers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (wbuf_wren_i) begin
            wbuf[wbuf_addr_i] <= wbuf_wdata_i;
        end
        if (ifmap_wren_i) begin
            ibuf[ifmap_wrptr_i] <= ifmap_wdata_i;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Dot-product sequencer
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        last_in   = {1'b0, idx_q} == in_num_q - 5'd1;
        last_node = {1'b0, node_q} == out_num_q - 4'd1;
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q    <= cnn_pkg::FS_IDLE;
            idx_q      <= 4'd0;
            node_q     <= 3'd0;
            fc_valid_o <= 1'b0;
            fc_last_o  <= 1'b0;
        end else begin
            fc_valid_o <= 1'b0;
            fc_last_o  <= 1'b0;
            case (state_q)
                cnn_pkg::FS_IDLE: begin
                    if (start_i) begin
                        state_q <= cnn_pkg::FS_MAC;
                        idx_q   <= 4'd0;
                        node_q  <= 3'd0;
                    end
                end
                cnn_pkg::FS_MAC: begin
                    idx_q <= idx_q + 4'd1;
                    if (last_in) begin
                        state_q <= cnn_pkg::FS_EMIT;
                    end
                end
                cnn_pkg::FS_EMIT: begin
                    fc_valid_o <= 1'b1;
                    fc_last_o  <= last_node;
                    idx_q      <= 4'd0;
                    node_q     <= node_q + 3'd1;
                    state_q    <= last_node ? cnn_pkg::FS_IDLE : cnn_pkg::FS_MAC;
                end
                default: state_q <= cnn_pkg::FS_IDLE;
            endcase
        end
    end

    // Weight of node j and input i lives at j*16 + i
    always_ff @(posedge clk) begin
        if (state_q == cnn_pkg::FS_IDLE && start_i) begin
            in_num_q  <= in_node_num_i;
            out_num_q <= out_node_num_i;
        end
        if (state_q == cnn_pkg::FS_MAC) begin
            acc_q <= (idx_q == 4'd0) ? ibuf[idx_q] * wbuf[{node_q, idx_q}]
                                     : acc_q + ibuf[idx_q] * wbuf[{node_q, idx_q}];
        end
        if (state_q == cnn_pkg::FS_EMIT) begin
            fc_result_o <= cnn_pkg::requant(acc_q);
        end
    end

endmodule

// File: hw/cnn_top.sv
module cnn_top (
    input  logic                         clk,
    input  logic                         rst_n_i,

    input  cnn_pkg::op_e                 op_i,
    input  logic [1:0]                   nth_conv_i,
    input  logic [3:0]                   ofmap_size_i,
    input  logic [4:0]                   in_node_num_i,
    input  logic [3:0]                   out_node_num_i,

    input  logic                         wea_i,
    input  logic [cnn_pkg::CONV_AW-1:0]  addra_i,
    input  cnn_pkg::data_t               dia_i,

    input  logic                         wbuf_wren_i,
    input  logic [6:0]                   wbuf_addr_i,
    input  cnn_pkg::data_t               wbuf_wdata_i,
    input  logic                         ifmap_wren_i,
    input  logic [3:0]                   ifmap_wrptr_i,
    input  cnn_pkg::data_t               ifmap_wdata_i,

    output logic                         fc_valid_o,
    output logic                         fc_last_o,
    output cnn_pkg::data_t               fc_result_o,

    output logic                         pool_valid_o [cnn_pkg::LANES],
    output logic                         pool_last_o [cnn_pkg::LANES],
    output cnn_pkg::data_t               pool_result_o [cnn_pkg::LANES],
    output cnn_pkg::pool_addr_t          pool_result_address_o [cnn_pkg::LANES]
);

    logic start_conv;
    logic start_fc;
    logic fc_busy_q;
    logic fc_busy;

    logic conv_valid;
    cnn_pkg::data_t conv_data [cnn_pkg::LANES];
    logic [3:0] conv_row;
    logic [3:0] conv_col;

    // Each block ignores its strobe while busy, and a conv request is
    // dropped while the FC engine is running
    always_comb begin
        fc_busy    = fc_busy_q && !fc_last_o;
        start_conv = (op_i == cnn_pkg::OP_CONV) && !fc_busy;
        start_fc   = op_i == cnn_pkg::OP_FC;
    end

    // Follows the FC engine, which is idle again once fc_last_o is high
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            fc_busy_q <= 1'b0;
        end else begin
            fc_busy_q <= start_fc || fc_busy;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Convolution and pooling
    //////////////////////////////////////////////////////////////////////

    conv_array u_conv_array (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .start_i      (start_conv),
        .nth_conv_i   (nth_conv_i),
        .ofmap_size_i (ofmap_size_i),
        .wea_i        (wea_i),
        .addra_i      (addra_i),
        .dia_i        (dia_i),
        .conv_valid_o (conv_valid),
        .conv_data_o  (conv_data),
        .conv_row_o   (conv_row),
        .conv_col_o   (conv_col)
    );

    for (genvar l = 0; l < cnn_pkg::LANES; l++) begin : g_pool
        pool_lane u_pool_lane (
            .clk                   (clk),
            .rst_n_i               (rst_n_i),
            .start_i               (start_conv),
            .ofmap_size_i          (ofmap_size_i),
            .conv_valid_i          (conv_valid),
            .conv_data_i           (conv_data[l]),
            .conv_row_i            (conv_row),
            .conv_col_i            (conv_col),
            .pool_valid_o          (pool_valid_o[l]),
            .pool_last_o           (pool_last_o[l]),
            .pool_result_o         (pool_result_o[l]),
            .pool_result_address_o (pool_result_address_o[l])
        );
    end

    //////////////////////////////////////////////////////////////////////
    // Fully connected
    //////////////////////////////////////////////////////////////////////

    fc_engine u_fc_engine (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .start_i        (start_fc),
        .in_node_num_i  (in_node_num_i),
        .out_node_num_i (out_node_num_i),
        .wbuf_wren_i    (wbuf_wren_i),
        .wbuf_addr_i    (wbuf_addr_i),
        .wbuf_wdata_i   (wbuf_wdata_i),
        .ifmap_wren_i   (ifmap_wren_i),
        .ifmap_wrptr_i  (ifmap_wrptr_i),
        .ifmap_wdata_i  (ifmap_wdata_i),
        .fc_valid_o     (fc_valid_o),
        .fc_last_o      (fc_last_o),
        .fc_result_o    (fc_result_o)
    );

endmodule

// File: verification/cnn_props.sv
module cnn_props (
    input logic clk,
    input logic rst_n_i,
    input logic fc_valid_i,
    input logic fc_last_i,
    input logic pool_valid_i [cnn_pkg::LANES],
    input logic pool_last_i [cnn_pkg::LANES]
);
    timeunit 1ns;
    timeprecision 1ps;

    fc_last_has_valid: assert property (
        @(posedge clk) disable iff (!rst_n_i) fc_last_i |-> fc_valid_i
    ) else $error("fc_last_o high without fc_valid_o");

    fc_quiet_in_reset: assert property (
        @(posedge clk) !rst_n_i |-> !fc_valid_i
    ) else $error("fc_valid_o high during reset");

    // Every node needs at least one MAC cycle before its EMIT
    fc_valid_spacing: assert property (
        @(posedge clk) disable iff (!rst_n_i) fc_valid_i |=> !fc_valid_i
    ) else $error("fc_valid_o pulses too close together");

    for (genvar l = 0; l < cnn_pkg::LANES; l++) begin : g_lane
        pool_last_has_valid: assert property (
            @(posedge clk) disable iff (!rst_n_i) pool_last_i[l] |-> pool_valid_i[l]
        ) else $error("pool_last_o high without pool_valid_o on lane %0d", l);

        pool_quiet_in_reset: assert property (
            @(posedge clk) !rst_n_i |-> !pool_valid_i[l]
        ) else $error("pool_valid_o high during reset on lane %0d", l);
    end

endmodule

bind cnn_top cnn_props u_props (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .fc_valid_i   (fc_valid_o),
    .fc_last_i    (fc_last_o),
    .pool_valid_i (pool_valid_o),
    .pool_last_i  (pool_last_o)
);

// File: verification/cnn_tb.sv
module cnn_tb;
    timeunit 1ns;
    timeprecision 1ps;

    typedef enum logic [1:0] {
        FILL_RAND,
        FILL_POS,
        FILL_NEG
    } fill_e;

    typedef struct packed {
        cnn_pkg::op_e op;
        logic [1:0]   nth;
        logic [3:0]   size;
        logic [4:0]   in_num;
        logic [3:0]   out_num;
        fill_e        fill;
        cnn_pkg::op_e extra;
    } case_t;

    // The last column is a second request sent while the run is still busy
    case_t cases [10] = '{
        '{cnn_pkg::OP_CONV, 2'd0, 4'd2,  5'd0,  4'd0, FILL_RAND, cnn_pkg::OP_IDLE},
        '{cnn_pkg::OP_CONV, 2'd1, 4'd6,  5'd0,  4'd0, FILL_RAND, cnn_pkg::OP_IDLE},
        '{cnn_pkg::OP_CONV, 2'd2, 4'd14, 5'd0,  4'd0, FILL_RAND, cnn_pkg::OP_IDLE},
        '{cnn_pkg::OP_CONV, 2'd3, 4'd4,  5'd0,  4'd0, FILL_POS,  cnn_pkg::OP_IDLE},
        '{cnn_pkg::OP_CONV, 2'd1, 4'd2,  5'd0,  4'd0, FILL_NEG,  cnn_pkg::OP_IDLE},
        '{cnn_pkg::OP_CONV, 2'd3, 4'd8,  5'd0,  4'd0, FILL_RAND, cnn_pkg::OP_CONV},
        '{cnn_pkg::OP_FC,   2'd0, 4'd0,  5'd16, 4'd8, FILL_RAND, cnn_pkg::OP_IDLE},
        '{cnn_pkg::OP_FC,   2'd0, 4'd0,  5'd1,  4'd1, FILL_RAND, cnn_pkg::OP_IDLE},
        '{cnn_pkg::OP_FC,   2'd0, 4'd0,  5'd5,  4'd3, FILL_RAND, cnn_pkg::OP_FC},
        '{cnn_pkg::OP_FC,   2'd0, 4'd2,  5'd4,  4'd2, FILL_RAND, cnn_pkg::OP_CONV}
    };

    logic                        clk;
    logic                        rst_n_i;
    cnn_pkg::op_e                op_i;
    logic [1:0]                  nth_conv_i;
    logic [3:0]                  ofmap_size_i;
    logic [4:0]                  in_node_num_i;
    logic [3:0]                  out_node_num_i;
    logic                        wea_i;
    logic [cnn_pkg::CONV_AW-1:0] addra_i;
    cnn_pkg::data_t              dia_i;
    logic                        wbuf_wren_i;
    logic [6:0]                  wbuf_addr_i;
    cnn_pkg::data_t              wbuf_wdata_i;
    logic                        ifmap_wren_i;
    logic [3:0]                  ifmap_wrptr_i;
    cnn_pkg::data_t              ifmap_wdata_i;
    logic                        fc_valid_o;
    logic                        fc_last_o;
    cnn_pkg::data_t              fc_result_o;
    logic                        pool_valid_o [cnn_pkg::LANES];
    logic                        pool_last_o [cnn_pkg::LANES];
    cnn_pkg::data_t              pool_result_o [cnn_pkg::LANES];
    cnn_pkg::pool_addr_t         pool_result_address_o [cnn_pkg::LANES];

    // Copies of what was loaded, for the reference model
    cnn_pkg::data_t      w_ref [64];
    cnn_pkg::data_t      px_ref [256];
    cnn_pkg::data_t      fcw_ref [128];
    cnn_pkg::data_t      fcx_ref [16];
    cnn_pkg::data_t      exp_pool [cnn_pkg::LANES][49];
    cnn_pkg::pool_addr_t exp_addr [cnn_pkg::LANES][49];
    cnn_pkg::data_t      exp_fc [8];
    int                  exp_pool_n;
    int                  exp_fc_n;

    logic [31:0] rng_state = 32'h13f7a823;
    int errors = 0;
    int checks = 0;
    int cycle_count = 0;
    int cycle_limit = 0;

    cnn_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout after %0d cycles, the DUT stopped producing results", cycle_limit);
            $display("TB FAILED");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Stimulus data and reference model
    ////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function cnn_pkg::data_t rand_byte();
        rng_state = xorshift32(rng_state);
        return cnn_pkg::data_t'(rng_state[15:8]);
    endfunction

    // Arithmetic shift by 4, then clamp to the signed byte range
    function automatic int requantize(input int acc);
        int s;
        s = acc >>> 4;
        if (s > 127) begin
            return 127;
        end
        if (s < -128) begin
            return -128;
        end
        return s;
    endfunction

    function automatic int conv_relu(input int lane, input int n, input int s,
                                     input int r, input int c);
        int acc;
        int q;
        acc = 0;
        for (int k = 0; k < 4; k++) begin
            acc += int'(px_ref[(r + k / 2) * (s + 1) + c + k % 2])
                 * int'(w_ref[n * 16 + lane * 4 + k]);
        end
        q = requantize(acc);
        return (q < 0) ? 0 : q;
    endfunction

    task automatic build_pool_model(input case_t tc);
        int s;
        int half;
        int m;
        int v;
        s = int'(tc.size);
        half = s / 2;
        exp_pool_n = half * half;
        for (int l = 0; l < cnn_pkg::LANES; l++) begin
            for (int pr = 0; pr < half; pr++) begin
                for (int pc = 0; pc < half; pc++) begin
                    m = 0;
                    for (int k = 0; k < 4; k++) begin
                        v = conv_relu(l, int'(tc.nth), s, 2 * pr + k / 2, 2 * pc + k % 2);
                        m = (v > m) ? v : m;
                    end
                    exp_pool[l][pr * half + pc] = cnn_pkg::data_t'(m);
                    exp_addr[l][pr * half + pc] = cnn_pkg::pool_addr_t'(pr * half + pc);
                end
            end
        end
    endtask

    task automatic build_fc_model(input case_t tc);
        int acc;
        exp_fc_n = int'(tc.out_num);
        for (int j = 0; j < exp_fc_n; j++) begin
            acc = 0;
            for (int i = 0; i < int'(tc.in_num); i++) begin
                acc += int'(fcx_ref[i]) * int'(fcw_ref[j * 16 + i]);
            end
            exp_fc[j] = cnn_pkg::data_t'(requantize(acc));
        end
    endtask

    task automatic load_conv(input case_t tc);
        int side;
        side = int'(tc.size) + 1;
        for (int a = 0; a < 64; a++) begin
            case (tc.fill)
                FILL_POS: w_ref[a] = cnn_pkg::data_t'(127);
                FILL_NEG: w_ref[a] = cnn_pkg::data_t'(-128);
                default:  w_ref[a] = rand_byte();
            endcase
            wea_i   = 1'b1;
            addra_i = 9'(a);
            dia_i   = w_ref[a];
            @(negedge clk);
        end
        for (int a = 0; a < side * side; a++) begin
            px_ref[a] = (tc.fill == FILL_RAND) ? rand_byte() : cnn_pkg::data_t'(127);
            addra_i   = 9'(256 + a);
            dia_i     = px_ref[a];
            @(negedge clk);
        end
        wea_i = 1'b0;
    endtask

    task automatic load_fc();
        for (int a = 0; a < 128; a++) begin
            fcw_ref[a]   = rand_byte();
            wbuf_wren_i  = 1'b1;
            wbuf_addr_i  = 7'(a);
            wbuf_wdata_i = fcw_ref[a];
            ifmap_wren_i = a < 16;
            if (a < 16) begin
                fcx_ref[a]    = rand_byte();
                ifmap_wrptr_i = 4'(a);
                ifmap_wdata_i = fcx_ref[a];
            end
            @(negedge clk);
        end
        wbuf_wren_i  = 1'b0;
        ifmap_wren_i = 1'b0;
    endtask

    ////////////////////////////////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////////////////////////////////

    task automatic check_pool(input int lane, input cnn_pkg::data_t got,
                              input cnn_pkg::data_t exp, input cnn_pkg::pool_addr_t got_a,
                              input cnn_pkg::pool_addr_t exp_a);
        checks += 2;
        if (got !== exp) begin
            errors++;
            $display("FAILED %0t pool_result_o[%0d] got %0d expected %0d",
                     $time, lane, got, exp);
        end
        if (got_a !== exp_a) begin
            errors++;
            $display("FAILED %0t pool_result_address_o[%0d] got %0d expected %0d",
                     $time, lane, got_a, exp_a);
        end
    endtask

    task automatic check_fc(input cnn_pkg::data_t got, input cnn_pkg::data_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %0t fc_result_o got %0d expected %0d", $time, got, exp);
        end
    endtask

    task automatic check_last(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    ////////////////////////////////////////////////////////////////////
    // Case runner
    ////////////////////////////////////////////////////////////////////

    function automatic int case_budget(input case_t tc);
        int s;
        s = int'(tc.size);
        if (tc.op == cnn_pkg::OP_CONV) begin
            return 64 + (s + 1) * (s + 1) + 5 * s * s + 200;
        end
        return 128 + (int'(tc.in_num) + 1) * int'(tc.out_num) + 200;
    endfunction

    task automatic run_case(input int idx);
        case_t tc;
        int pool_seen [cnn_pkg::LANES];
        int fc_seen;
        int cyc;
        int tail;
        int errors_before;
        logic done;
        tc = cases[idx];
        errors_before = errors;
        if (tc.op == cnn_pkg::OP_CONV) begin
            load_conv(tc);
            build_pool_model(tc);
            exp_fc_n = 0;
        end else begin
            load_fc();
            build_fc_model(tc);
            exp_pool_n = 0;
        end
        op_i           = tc.op;
        nth_conv_i     = tc.nth;
        ofmap_size_i   = tc.size;
        in_node_num_i  = tc.in_num;
        out_node_num_i = tc.out_num;
        @(negedge clk);
        op_i = cnn_pkg::OP_IDLE;
        foreach (pool_seen[l]) begin
            pool_seen[l] = 0;
        end
        fc_seen = 0;
        cyc = 0;
        tail = 0;
        // Keep watching for a while after the last result to catch extras
        while (tail < 20) begin
            for (int l = 0; l < cnn_pkg::LANES; l++) begin
                if (pool_valid_o[l]) begin
                    if (pool_seen[l] < exp_pool_n) begin
                        check_pool(l, pool_result_o[l], exp_pool[l][pool_seen[l]],
                                   pool_result_address_o[l], exp_addr[l][pool_seen[l]]);
                        check_last($sformatf("pool_last_o[%0d]", l), pool_last_o[l],
                                   pool_seen[l] == exp_pool_n - 1);
                    end
                    pool_seen[l]++;
                end
            end
            if (fc_valid_o) begin
                if (fc_seen < exp_fc_n) begin
                    check_fc(fc_result_o, exp_fc[fc_seen]);
                    check_last("fc_last_o", fc_last_o, fc_seen == exp_fc_n - 1);
                end
                fc_seen++;
            end
            if (cyc == 3) begin
                op_i = tc.extra;
            end
            if (cyc == 4) begin
                op_i = cnn_pkg::OP_IDLE;
            end
            done = fc_seen >= exp_fc_n;
            for (int l = 0; l < cnn_pkg::LANES; l++) begin
                done = done && (pool_seen[l] >= exp_pool_n);
            end
            if (done) begin
                tail++;
            end
            cyc++;
            @(negedge clk);
        end
        for (int l = 0; l < cnn_pkg::LANES; l++) begin
            checks++;
            if (pool_seen[l] != exp_pool_n) begin
                errors++;
                $display("Lane %0d gave %0d pooled results where %0d were expected",
                         l, pool_seen[l], exp_pool_n);
            end
        end
        checks++;
        if (fc_seen != exp_fc_n) begin
            errors++;
            $display("FC gave %0d results where %0d were expected", fc_seen, exp_fc_n);
        end
        $display("case %0d %s set %0d size %0d in %0d out %0d: %0d errors", idx,
                 (tc.op == cnn_pkg::OP_CONV) ? "conv" : "fc", tc.nth, tc.size,
                 tc.in_num, tc.out_num, errors - errors_before);
    endtask

    initial begin
        foreach (cases[i]) begin
            cycle_limit += case_budget(cases[i]);
        end
        cycle_limit += 20;
        op_i           = cnn_pkg::OP_IDLE;
        nth_conv_i     = 2'd0;
        ofmap_size_i   = 4'd0;
        in_node_num_i  = 5'd0;
        out_node_num_i = 4'd0;
        wea_i          = 1'b0;
        addra_i        = '0;
        dia_i          = '0;
        wbuf_wren_i    = 1'b0;
        wbuf_addr_i    = '0;
        wbuf_wdata_i   = '0;
        ifmap_wren_i   = 1'b0;
        ifmap_wrptr_i  = '0;
        ifmap_wdata_i  = '0;
        // Give the asynchronous reset a real falling edge
        rst_n_i = 1'b1;
        #2;
        rst_n_i = 1'b0;
        repeat (10) @(negedge clk);
        rst_n_i = 1'b1;
        @(negedge clk);
        foreach (cases[i]) begin
            run_case(i);
        end
        $display("cases %0d, checks %0d, errors %0d", $size(cases), checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: all.f
hw/cnn_pkg.sv
hw/conv_array.sv
hw/pool_lane.sv
hw/fc_engine.sv
hw/cnn_top.sv
verification/cnn_props.sv
verification/cnn_tb.sv

// File: Makefile
# Verilator build and run for the CNN accelerator testbench

VERILATOR ?= verilator
TOP       ?= cnn_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal --timescale 1ns/1ps

SRCS := $(shell cat $(FILELIST))
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) 2>&1 | tee $(LOG)
	@grep -qx "TB PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
